/* Bender.yml */
package:
  name: sqrt_unit

sources:
  - files:
      - sqrt_pkg.sv
      - sqrt_control.sv
      - sqrt_datapath.sv
      - sqrt_result_fifo.sv
      - sqrt_top.sv
  - target: test
    files:
      - sqrt_properties.sv
      - sqrt_tb.sv

/* list.f */
sqrt_pkg.sv
sqrt_control.sv
sqrt_datapath.sv
sqrt_result_fifo.sv
sqrt_top.sv
sqrt_properties.sv
sqrt_tb.sv

/* sqrt_control.sv */
`timescale 1ns/1ps

module sqrt_control import sqrt_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic in_valid,
  input  logic has_space,
  input  logic trial_negative,
  input  logic last_iteration,
  output logic in_ready,
  output logic load,
  output logic clear,
  output logic shift,
  output logic accept,
  output logic iterate,
  output logic advance,
  output logic done
);

  sqrt_state_t state;
  sqrt_state_t state_next;
  logic        in_fire;

  assign in_ready = clear & has_space; // idle and a result slot is free.
  assign in_fire  = in_valid & in_ready;
  assign load     = clear & in_fire;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_START;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_START: begin
        if (in_fire) begin
          state_next = ST_SHIFT;
        end
      end
      ST_SHIFT: begin
        state_next = ST_CHECK;
      end
      ST_CHECK: begin
        state_next = trial_negative ? ST_ITERATE : ST_ACCEPT; // keep bit zero on a borrow.
      end
      ST_ACCEPT: begin
        state_next = ST_ITERATE;
      end
      ST_ITERATE: begin
        state_next = last_iteration ? ST_DONE : ST_ADVANCE;
      end
      ST_ADVANCE: begin
        state_next = ST_SHIFT;
      end
      ST_DONE: begin
        state_next = ST_START;
      end
      default: begin
        state_next = ST_START;
      end
    endcase
  end

  // one strobe per state, none in the unused code.
  always_comb begin
    clear   = 1'b0;
    shift   = 1'b0;
    accept  = 1'b0;
    iterate = 1'b0;
    advance = 1'b0;
    done    = 1'b0;
    case (state)
      ST_START: begin
        clear = 1'b1;
      end
      ST_SHIFT: begin
        shift = 1'b1;
      end
      ST_CHECK: begin
        clear = 1'b0; // decision only.
      end
      ST_ACCEPT: begin
        accept = 1'b1;
      end
      ST_ITERATE: begin
        iterate = 1'b1;
      end
      ST_ADVANCE: begin
        advance = 1'b1;
      end
      ST_DONE: begin
        done = 1'b1; // pushes the result.
      end
      default: begin
        clear = 1'b0;
      end
    endcase
  end

endmodule

/* sqrt_datapath.sv */
`timescale 1ns/1ps

module sqrt_datapath import sqrt_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       load,
  input  logic       clear,
  input  logic       shift,
  input  logic       accept,
  input  logic       iterate,
  input  logic       advance,
  input  radicand_t  in_radicand,
  output logic       trial_negative,
  output logic       last_iteration,
  output root_t      push_root,
  output remainder_t push_remainder
);

  radicand_t  radicand_q;
  remainder_t remainder_q;
  trial_t     trial_q;
  root_t      root_q;
  count_t     count_q;
  logic       bit_q;
  trial_t     shifted;
  trial_t     divisor;
  trial_t     trial_d;

  // the remainder is below 256 whenever a new digit pair comes in.
  assign shifted = {remainder_q[ROOT_WIDTH-1:0], radicand_q[RAD_WIDTH-1 -: 2]};
  assign divisor = {root_q, 2'b01}; // 4*root + 1.
  assign trial_d = shifted - divisor;

  assign trial_negative = trial_q[$bits(trial_t)-1];
  assign last_iteration = (count_q == '0);
  assign push_root      = root_q;
  assign push_remainder = remainder_q;

  always_ff @(posedge clk) begin
    if (load) begin
      radicand_q <= in_radicand;
    end else if (shift) begin
      radicand_q <= {radicand_q[RAD_WIDTH-3:0], 2'b00}; // next digit pair on top.
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      remainder_q <= '0;
    end else if (shift) begin
      // wraps only when the trial fits, and then accept overwrites it.
      remainder_q <= shifted[ROOT_WIDTH:0];
    end else if (accept) begin
      remainder_q <= trial_q[ROOT_WIDTH:0];
    end
  end

  always_ff @(posedge clk) begin
    if (clear) begin
      trial_q <= '0;
    end else if (shift) begin
      trial_q <= trial_d;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      root_q <= '0;
    end else if (iterate) begin
      root_q <= {root_q[ROOT_WIDTH-2:0], bit_q}; // append the new root bit.
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else if (load) begin
      count_q <= count_t'(ROOT_WIDTH - 1);
    end else if (advance) begin
      count_q <= count_q - count_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bit_q <= 1'b0;
    end else if (clear || advance) begin
      bit_q <= 1'b0;
    end else if (accept) begin
      bit_q <= 1'b1; // trial was non-negative.
    end
  end

endmodule

/* sqrt_pkg.sv */
package sqrt_pkg;

  localparam int RAD_WIDTH  = 16;
  localparam int ROOT_WIDTH = RAD_WIDTH / 2;

  // input value.
  typedef logic [RAD_WIDTH-1:0] radicand_t;

  // integer root.
  typedef logic [ROOT_WIDTH-1:0] root_t;

  // radicand minus root squared, at most 2*root.
  typedef logic [ROOT_WIDTH:0] remainder_t;

  // trial difference, top bit is the sign.
  typedef logic [ROOT_WIDTH+1:0] trial_t;

  // iteration index, counts down to zero.
  typedef logic [2:0] count_t;

  typedef enum logic [2:0] {
    ST_START   = 3'd0,
    ST_SHIFT   = 3'd1,
    ST_CHECK   = 3'd2,
    ST_ACCEPT  = 3'd3,
    ST_ITERATE = 3'd4,
    ST_ADVANCE = 3'd5,
    ST_DONE    = 3'd6
  } sqrt_state_t;

endpackage

/* sqrt_properties.sv */
`timescale 1ns/1ps

module sqrt_properties import sqrt_pkg::*; (
  input logic       clk,
  input logic       rst,
  input logic       in_valid,
  input logic       in_ready,
  input logic       out_valid,
  input logic       out_ready,
  input root_t      out_root,
  input remainder_t out_remainder
);

  // a reset edge empties the result FIFO.
  a_reset_empty: assert property (@(posedge clk) $past(rst) |-> !out_valid)
    else $error("out_valid is high after a reset edge");

  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_root) && $stable(out_remainder))
    else $error("output changed or dropped before out_ready");

  // the controller leaves ST_START on every transfer.
  a_ready_after_fire: assert property (@(posedge clk) disable iff (rst)
    in_valid && in_ready |=> !in_ready)
    else $error("in_ready high right after an input transfer");

endmodule

bind sqrt_top sqrt_properties i_properties (
  .clk           (clk),
  .rst           (rst),
  .in_valid      (in_valid),
  .in_ready      (in_ready),
  .out_valid     (out_valid),
  .out_ready     (out_ready),
  .out_root      (out_root),
  .out_remainder (out_remainder)
);

/* sqrt_result_fifo.sv */
`timescale 1ns/1ps

module sqrt_result_fifo import sqrt_pkg::*; #(
  parameter int FIFO_DEPTH = 2
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       push,
  input  logic       out_ready,
  input  root_t      push_root,
  input  remainder_t push_remainder,
  output logic       has_space,
  output logic       out_valid,
  output root_t      out_root,
  output remainder_t out_remainder
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_SLOT  = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(FIFO_DEPTH);

  root_t            root_mem [FIFO_DEPTH];
  remainder_t       rem_mem  [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == LAST_SLOT) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign has_space     = (count != FULL_COUNT);
  assign out_valid     = (count != '0);
  assign wr_en         = push & has_space;
  assign rd_en         = out_valid & out_ready;
  assign out_root      = root_mem[rd_ptr]; // oldest entry.
  assign out_remainder = rem_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      root_mem[wr_ptr] <= push_root;
      rem_mem[wr_ptr]  <= push_remainder;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count; // both or neither.
      endcase
    end
  end

endmodule

/* sqrt_tb.sv */
`timescale 1ns/1ps

module sqrt_tb import sqrt_pkg::*; ();

  localparam int FIFO_DEPTH  = 2;
  localparam int NUM_RANDOM  = 300;
  localparam int CYCLE_LIMIT = NUM_RANDOM * 40 * 3;

  logic       clk = 1'b0;
  logic       rst;
  logic       in_valid;
  logic       in_ready;
  radicand_t  in_radicand;
  logic       out_valid;
  logic       out_ready;
  root_t      out_root;
  remainder_t out_remainder;

  integer     seed = 32'hf4f9_6b24;
  radicand_t  expect_q [$]; // radicands still waiting for their result.
  radicand_t  edge_values [6] = '{16'd0, 16'd1, 16'd2, 16'd3, 16'd65535, 16'd65025};
  int         errors = 0;
  int         checks = 0;
  int         transfers = 0;
  int         results = 0;
  int         discarded = 0;
  int         cycles = 0;
  logic       stall = 1'b0;

  sqrt_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_dut (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_radicand   (in_radicand),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_root      (out_root),
    .out_remainder (out_remainder)
  );

  always #5 clk = ~clk;

  // largest r with r*r not above v.
  function automatic root_t model_root(input radicand_t v);
    int r;
    r = 0;
    while ((r + 1) * (r + 1) <= int'(v)) begin
      r++;
    end
    return root_t'(r);
  endfunction

  task automatic check_root(input string name, input root_t exp, input root_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_remainder(input string name, input remainder_t exp,
                                 input remainder_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %0t %s expected %0b actual %0b", $time, name, exp, act);
    end
  endtask

  task automatic check_output();
    radicand_t v;
    root_t     r;
    results++;
    if (expect_q.size() == 0) begin
      errors++;
      $display("%0t: a result came out with no radicand waiting for it", $time);
    end else begin
      v = expect_q.pop_front();
      r = model_root(v);
      check_root("out_root", r, out_root);
      check_remainder("out_remainder", remainder_t'(int'(v) - int'(r) * int'(r)),
                      out_remainder);
      if (out_remainder > {out_root, 1'b0}) begin
        errors++;
        $display("ERR %0t out_remainder expected at most %0d actual %0d", $time,
                 {out_root, 1'b0}, out_remainder);
      end
    end
  endtask

  task automatic check_idle();
    @(negedge clk);
    check_flag("out_valid", 1'b0, out_valid);
    check_flag("in_ready", 1'b1, in_ready);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // holds the value until the unit takes it.
  task automatic send_value(input radicand_t v);
    in_valid    = 1'b1;
    in_radicand = v;
    @(negedge clk);
    while (rst || !in_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    @(negedge clk);
    while (expect_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    discarded += expect_q.size(); // work in flight is lost with the reset.
    expect_q.delete();
    repeat (5) begin
      @(posedge clk);
    end
    #1;
    rst = 1'b0;
  endtask

  task automatic report_and_finish();
    $display("checks %0d, errors %0d, transfers %0d, results %0d, discarded %0d",
             checks, errors, transfers, results, discarded);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  // a transfer seen here happens on the next rising edge.
  always @(negedge clk) begin
    if (!rst && in_valid && in_ready) begin
      expect_q.push_back(in_radicand);
      transfers++;
    end
  end

  always @(negedge clk) begin
    if (!rst && out_valid && out_ready) begin
      check_output();
    end
  end

  always @(posedge clk) begin
    #1;
    out_ready = stall ? 1'b0 : (({$random(seed)} % 10) < 6); // about 60% high.
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      errors++;
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      report_and_finish();
    end
  end

  initial begin
    rst         = 1'b1;
    in_valid    = 1'b0;
    in_radicand = '0;
    out_ready   = 1'b0;
    repeat (5) begin
      @(posedge clk);
    end
    #1;
    rst = 1'b0;
    check_idle();
    @(posedge clk);
    #1;
    foreach (edge_values[i]) begin
      send_value(edge_values[i]);
    end
    for (int k = 0; k < 256; k++) begin
      send_value(radicand_t'(k * k));
    end
    for (int i = 0; i < NUM_RANDOM; i++) begin
      idle_cycles({$random(seed)} % 4);
      send_value(radicand_t'($random(seed)));
    end
    wait_drain();
    stall = 1'b1; // back-pressure, FIFO fills up.
    @(posedge clk);
    #1;
    repeat (FIFO_DEPTH) begin
      send_value(radicand_t'($random(seed)));
    end
    in_valid    = 1'b1;
    in_radicand = 16'd50000;
    repeat (60) begin
      @(negedge clk);
      check_flag("in_ready", 1'b0, in_ready);
    end
    check_flag("out_valid", 1'b1, out_valid);
    stall = 1'b0;
    send_value(16'd50000);
    wait_drain();
    stall = 1'b1; // one result queued, one in progress.
    @(posedge clk);
    #1;
    send_value(radicand_t'($random(seed)));
    idle_cycles(40);
    send_value(radicand_t'($random(seed)));
    idle_cycles(10);
    apply_reset();
    check_idle();
    stall = 1'b0;
    @(posedge clk);
    #1;
    repeat (20) begin
      send_value(radicand_t'($random(seed)));
    end
    wait_drain();
    if (transfers != results + discarded) begin
      errors++;
      $display("the count of results does not match the count of transfers");
    end
    report_and_finish();
  end

endmodule

/* sqrt_top.sv */
`timescale 1ns/1ps

module sqrt_top import sqrt_pkg::*; #(
  parameter int FIFO_DEPTH = 2
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid,
  output logic       in_ready,
  input  radicand_t  in_radicand,
  output logic       out_valid,
  input  logic       out_ready,
  output root_t      out_root,
  output remainder_t out_remainder
);

  logic       load;
  logic       clear;
  logic       shift;
  logic       accept;
  logic       iterate;
  logic       advance;
  logic       done;
  logic       has_space;
  logic       trial_negative;
  logic       last_iteration;
  root_t      push_root;
  remainder_t push_remainder;

  sqrt_control i_control (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .has_space      (has_space),
    .trial_negative (trial_negative),
    .last_iteration (last_iteration),
    .in_ready       (in_ready),
    .load           (load),
    .clear          (clear),
    .shift          (shift),
    .accept         (accept),
    .iterate        (iterate),
    .advance        (advance),
    .done           (done)
  );

  sqrt_datapath i_datapath (
    .clk            (clk),
    .rst            (rst),
    .load           (load),
    .clear          (clear),
    .shift          (shift),
    .accept         (accept),
    .iterate        (iterate),
    .advance        (advance),
    .in_radicand    (in_radicand),
    .trial_negative (trial_negative),
    .last_iteration (last_iteration),
    .push_root      (push_root),
    .push_remainder (push_remainder)
  );

  sqrt_result_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_result_fifo (
    .clk            (clk),
    .rst            (rst),
    .push           (done), // result is complete in ST_DONE.
    .out_ready      (out_ready),
    .push_root      (push_root),
    .push_remainder (push_remainder),
    .has_space      (has_space),
    .out_valid      (out_valid),
    .out_root       (out_root),
    .out_remainder  (out_remainder)
  );

endmodule
